/* mips_core.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/debug_ctrl.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/hazard_unit.sv
rtl/mips_core.sv
testbench/mips_core_assertions.sv
testbench/mips_core_tb.sv

/* rtl/debug_ctrl.sv */
`timescale 1ns/10ps

module debug_ctrl (
   input  logic i_clk,
   input  logic i_arst_n,
   input  logic i_continue,
   input  logic i_valid,
   output logic o_run_enb
);

   mips_pkg::dbg_state_t state;
   mips_pkg::dbg_state_t state_next;
   logic                 continue_q;
   logic                 valid_q;
   logic                 continue_rise;
   logic                 valid_rise;

   assign continue_rise = i_continue && !continue_q;
   assign valid_rise    = i_valid && !valid_q;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state      <= mips_pkg::HALT;
         continue_q <= 1'b0;
         valid_q    <= 1'b0;
      end else begin
         state      <= state_next;
         continue_q <= i_continue;
         valid_q    <= i_valid;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         mips_pkg::HALT: begin
            if (continue_rise) begin
               state_next = mips_pkg::RUN;
            end else if (valid_rise) begin
               state_next = mips_pkg::STEP;
            end
         end
         // single enabled cycle
         mips_pkg::STEP: state_next = continue_rise ? mips_pkg::RUN : mips_pkg::HALT;
         mips_pkg::RUN:  state_next = mips_pkg::RUN;   // left only by reset
         default:        state_next = mips_pkg::HALT;
      endcase
   end

   assign o_run_enb = (state == mips_pkg::RUN) || (state == mips_pkg::STEP);

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/10ps
`include "mips_cfg.svh"

module decode_stage (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_enb,
   input  mips_pkg::word_t      i_pc4,
   input  mips_pkg::word_t      i_instr,
   input  logic                 i_bubble,
   input  logic                 i_wb_we,
   input  mips_pkg::reg_num_t   i_wb_reg,
   input  mips_pkg::word_t      i_wb_data,
   output logic                 o_taken,
   output mips_pkg::word_t      o_target,
   output mips_pkg::reg_num_t   o_if_rs,    // raw fields for the hazard unit
   output mips_pkg::reg_num_t   o_if_rt,
   output logic                 o_branch,
   output mips_pkg::word_t      o_rs_val,
   output mips_pkg::word_t      o_rt_val,
   output mips_pkg::word_t      o_imm,
   output mips_pkg::reg_num_t   o_rs_num,
   output mips_pkg::reg_num_t   o_rt_num,
   output mips_pkg::reg_num_t   o_dst_num,
   output mips_pkg::alu_op_t    o_alu_op,
   output logic                 o_use_imm,
   output logic                 o_reg_write,
   output logic                 o_mem_read,
   output logic                 o_mem_write
);

   localparam int N_REGS = 1 << `NB_REG;

   mips_pkg::word_t    regs [N_REGS];
   logic [5:0]         opcode;
   logic [5:0]         funct;
   mips_pkg::reg_num_t rd;
   mips_pkg::word_t    imm_ext;
   mips_pkg::word_t    rs_val;
   mips_pkg::word_t    rt_val;
   mips_pkg::alu_op_t  alu_op;
   logic               use_imm;
   logic               reg_write;
   logic               mem_read;
   logic               mem_write;
   logic               dst_is_rt;
   logic               is_jump;

   function automatic mips_pkg::word_t rf_read(mips_pkg::reg_num_t num);
      mips_pkg::word_t val;
      if (num == '0) begin
         val = '0;
      end else if (i_wb_we && i_wb_reg == num) begin
         val = i_wb_data;   // write-first
      end else begin
         val = regs[num];
      end
      return val;
   endfunction

   assign opcode  = i_instr[31:26];
   assign o_if_rs = i_instr[25:21];
   assign o_if_rt = i_instr[20:16];
   assign rd      = i_instr[15:11];
   assign funct   = i_instr[5:0];
   assign imm_ext = {{16{i_instr[15]}}, i_instr[15:0]};

   always_comb begin
      rs_val = rf_read(o_if_rs);
      rt_val = rf_read(o_if_rt);
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_enb && i_wb_we) begin
         regs[i_wb_reg] <= i_wb_data;   // r0 already filtered in mem
      end
   end

   // main control
   always_comb begin
      alu_op    = mips_pkg::ALU_ADD;
      use_imm   = 1'b0;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      dst_is_rt = 1'b0;
      o_branch  = 1'b0;
      is_jump   = 1'b0;
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            reg_write = 1'b1;
            case (funct)
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               default:           reg_write = 1'b0;   // nop lands here
            endcase
         end
         mips_pkg::OP_ADDIU: begin
            use_imm   = 1'b1;
            reg_write = 1'b1;
            dst_is_rt = 1'b1;
         end
         mips_pkg::OP_LW: begin
            use_imm   = 1'b1;
            reg_write = 1'b1;
            mem_read  = 1'b1;
            dst_is_rt = 1'b1;
         end
         mips_pkg::OP_SW: begin
            use_imm   = 1'b1;
            mem_write = 1'b1;
         end
         mips_pkg::OP_BEQ: o_branch = 1'b1;
         mips_pkg::OP_J:   is_jump  = 1'b1;
         default: ;
      endcase
   end

   // no redirect while stalled, the compare may see stale operands
   assign o_taken  = ((o_branch && rs_val == rt_val) || is_jump) && !i_bubble;
   assign o_target = is_jump ? {i_pc4[31:28], i_instr[25:0], 2'b00}
                             : i_pc4 + {imm_ext[29:0], 2'b00};

   // ID/EX latch
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rs_val    <= '0;
         o_rt_val    <= '0;
         o_imm       <= '0;
         o_rs_num    <= '0;
         o_rt_num    <= '0;
         o_dst_num   <= '0;
         o_alu_op    <= mips_pkg::ALU_ADD;
         o_use_imm   <= 1'b0;
         o_reg_write <= 1'b0;
         o_mem_read  <= 1'b0;
         o_mem_write <= 1'b0;
      end else if (i_enb) begin
         o_rs_val    <= rs_val;
         o_rt_val    <= rt_val;
         o_imm       <= imm_ext;
         o_rs_num    <= o_if_rs;
         o_rt_num    <= o_if_rt;
         o_dst_num   <= dst_is_rt ? o_if_rt : rd;
         o_alu_op    <= alu_op;
         o_use_imm   <= use_imm;
         // bubble: payload is don't care, flags cleared
         o_reg_write <= reg_write && !i_bubble;
         o_mem_read  <= mem_read && !i_bubble;
         o_mem_write <= mem_write && !i_bubble;
      end
   end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
   input  logic               i_clk,
   input  logic               i_arst_n,
   input  logic               i_enb,
   input  mips_pkg::word_t    i_rs_val,
   input  mips_pkg::word_t    i_rt_val,
   input  mips_pkg::word_t    i_imm,
   input  mips_pkg::reg_num_t i_dst_num,
   input  mips_pkg::alu_op_t  i_alu_op,
   input  logic               i_use_imm,
   input  logic               i_reg_write,
   input  logic               i_mem_read,
   input  logic               i_mem_write,
   input  mips_pkg::fw_sel_t  i_fw_a,
   input  mips_pkg::fw_sel_t  i_fw_b,
   input  mips_pkg::word_t    i_wb_data,
   output mips_pkg::word_t    o_alu_res,
   output mips_pkg::word_t    o_store_data,
   output mips_pkg::reg_num_t o_dst_num,
   output logic               o_reg_write,
   output logic               o_mem_read,
   output logic               o_mem_write
);

   mips_pkg::word_t op_a;
   mips_pkg::word_t rt_fw;   // also the store data
   mips_pkg::word_t op_b;
   mips_pkg::word_t alu_res;

   function automatic mips_pkg::word_t fw_pick(mips_pkg::fw_sel_t sel,
                                               mips_pkg::word_t id_val,
                                               mips_pkg::word_t exmem_val,
                                               mips_pkg::word_t memwb_val);
      case (sel)
         mips_pkg::FW_EXMEM: return exmem_val;
         mips_pkg::FW_MEMWB: return memwb_val;
         default:            return id_val;
      endcase
   endfunction

   assign op_a  = fw_pick(i_fw_a, i_rs_val, o_alu_res, i_wb_data);
   assign rt_fw = fw_pick(i_fw_b, i_rt_val, o_alu_res, i_wb_data);
   assign op_b  = i_use_imm ? i_imm : rt_fw;

   always_comb begin
      case (i_alu_op)
         mips_pkg::ALU_SUB: alu_res = op_a - op_b;
         mips_pkg::ALU_AND: alu_res = op_a & op_b;
         mips_pkg::ALU_OR:  alu_res = op_a | op_b;
         mips_pkg::ALU_SLT: alu_res = mips_pkg::word_t'($signed(op_a) < $signed(op_b));
         default:           alu_res = op_a + op_b;   // add, also address calc
      endcase
   end

   // EX/MEM latch
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_alu_res    <= '0;
         o_store_data <= '0;
         o_dst_num    <= '0;
         o_reg_write  <= 1'b0;
         o_mem_read   <= 1'b0;
         o_mem_write  <= 1'b0;
      end else if (i_enb) begin
         o_alu_res    <= alu_res;
         o_store_data <= rt_fw;
         o_dst_num    <= i_dst_num;
         o_reg_write  <= i_reg_write;
         o_mem_read   <= i_mem_read;
         o_mem_write  <= i_mem_write;
      end
   end

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/10ps
`include "mips_cfg.svh"

module fetch_stage (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_enb,
   input  logic                 i_stall,
   input  logic                 i_taken,
   input  mips_pkg::word_t      i_target,
   input  logic                 i_imem_we,
   input  mips_pkg::imem_addr_t i_imem_addr,
   input  mips_pkg::word_t      i_imem_data,
   output mips_pkg::word_t      o_pc4,
   output mips_pkg::word_t      o_instr
);

   mips_pkg::word_t imem [`IMEM_DEPTH];
   mips_pkg::word_t pc;
   mips_pkg::word_t pc_plus4;
   mips_pkg::word_t fetched;
   logic            in_range;

   // load port works while halted too
   always_ff @(posedge i_clk) begin
      if (i_imem_we) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   assign pc_plus4 = pc + 'd4;
   assign in_range = (pc[`NB_BITS-1:`NB_IMEM_ADDR+2] == '0);
   assign fetched  = in_range ? imem[pc[`NB_IMEM_ADDR+1:2]] : '0; // nop past the end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc      <= '0;
         o_pc4   <= '0;
         o_instr <= '0;
      end else if (i_enb && !i_stall) begin
         pc      <= i_taken ? i_target : pc_plus4;
         o_pc4   <= pc_plus4;
         o_instr <= i_taken ? '0 : fetched;   // flushed slot becomes a nop
      end
   end

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit (
   input  mips_pkg::reg_num_t i_if_rs,
   input  mips_pkg::reg_num_t i_if_rt,
   input  mips_pkg::reg_num_t i_ex_rs,
   input  mips_pkg::reg_num_t i_ex_rt,
   input  mips_pkg::reg_num_t i_ex_dst,
   input  logic               i_ex_write,
   input  logic               i_ex_read,
   input  mips_pkg::reg_num_t i_mem_dst,
   input  logic               i_mem_write,
   input  mips_pkg::reg_num_t i_wb_dst,
   input  logic               i_wb_write,
   input  logic               i_branch,
   output mips_pkg::fw_sel_t  o_fw_a,
   output mips_pkg::fw_sel_t  o_fw_b,
   output logic               o_stall
);

   logic load_use;
   logic branch_wait;

   // pending write to src, r0 never counts
   function automatic logic hit(logic we, mips_pkg::reg_num_t dst, mips_pkg::reg_num_t src);
      return we && (dst != '0) && (dst == src);
   endfunction

   // EX/MEM is newer, so it wins
   assign o_fw_a = hit(i_mem_write, i_mem_dst, i_ex_rs) ? mips_pkg::FW_EXMEM :
                   hit(i_wb_write, i_wb_dst, i_ex_rs)   ? mips_pkg::FW_MEMWB :
                                                           mips_pkg::FW_RF;
   assign o_fw_b = hit(i_mem_write, i_mem_dst, i_ex_rt) ? mips_pkg::FW_EXMEM :
                   hit(i_wb_write, i_wb_dst, i_ex_rt)   ? mips_pkg::FW_MEMWB :
                                                           mips_pkg::FW_RF;

   assign load_use = hit(i_ex_read, i_ex_dst, i_if_rs) || hit(i_ex_read, i_ex_dst, i_if_rt);

   // beq compares in decode, MEM/WB gets there through the rf bypass
   assign branch_wait = i_branch &&
                        (hit(i_ex_write, i_ex_dst, i_if_rs) || hit(i_ex_write, i_ex_dst, i_if_rt) ||
                         hit(i_mem_write, i_mem_dst, i_if_rs) ||
                         hit(i_mem_write, i_mem_dst, i_if_rt));

   assign o_stall = load_use || branch_wait;

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mem_stage (
   input  logic               i_clk,
   input  logic               i_arst_n,
   input  logic               i_enb,
   input  mips_pkg::word_t    i_alu_res,
   input  mips_pkg::word_t    i_store_data,
   input  mips_pkg::reg_num_t i_dst_num,
   input  logic               i_reg_write,
   input  logic               i_mem_read,
   input  logic               i_mem_write,
   output logic               o_wb_we,
   output mips_pkg::reg_num_t o_wb_reg,
   output mips_pkg::word_t    o_wb_data
);

   mips_pkg::word_t          dmem [`DMEM_DEPTH];
   logic [`NB_DMEM_ADDR-1:0] addr;
   mips_pkg::word_t          load_q;
   mips_pkg::word_t          alu_q;
   logic                     load_sel_q;
   logic                     we_q;

   assign addr = i_alu_res[`NB_DMEM_ADDR+1:2];   // word addressed

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (i_enb && i_mem_write) begin
         dmem[addr] <= i_store_data;
      end
   end

   // MEM/WB latch
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         we_q       <= 1'b0;
         o_wb_reg   <= '0;
         load_q     <= '0;
         alu_q      <= '0;
         load_sel_q <= 1'b0;
      end else if (i_enb) begin
         we_q       <= i_reg_write && (i_dst_num != '0);   // r0 writes dropped here
         o_wb_reg   <= i_dst_num;
         load_q     <= dmem[addr];
         alu_q      <= i_alu_res;
         load_sel_q <= i_mem_read;
      end
   end

   // write-back mux
   assign o_wb_data = load_sel_q ? load_q : alu_q;
   assign o_wb_we   = we_q && i_enb;   // one pulse per enabled cycle

endmodule

/* rtl/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath
`define NB_BITS      32   // data and instruction width
`define NB_REG       5    // register number width

// memories, sizes in words
`define IMEM_DEPTH   64
`define DMEM_DEPTH   32
`define NB_IMEM_ADDR 6
`define NB_DMEM_ADDR 5

`endif

/* rtl/mips_core.sv */
`timescale 1ns/10ps

module mips_core (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_continue,
   input  logic                 i_valid,    // rising edge steps one cycle
   input  logic                 i_imem_we,
   input  mips_pkg::imem_addr_t i_imem_addr,
   input  mips_pkg::word_t      i_imem_data,
   output logic                 o_wb_we,
   output mips_pkg::reg_num_t   o_wb_reg,
   output mips_pkg::word_t      o_wb_data
);

   logic               debug_enb;
   logic               hz_stall;

   // fetch <-> decode
   mips_pkg::word_t    fet_2_dec_pc4;
   mips_pkg::word_t    fet_2_dec_instr;
   logic               dec_2_fet_taken;
   mips_pkg::word_t    dec_2_fet_target;

   // decode -> hazard unit
   mips_pkg::reg_num_t dec_2_hz_rs;
   mips_pkg::reg_num_t dec_2_hz_rt;
   logic               dec_2_hz_branch;

   // ID/EX
   mips_pkg::word_t    dec_2_ex_rs_val;
   mips_pkg::word_t    dec_2_ex_rt_val;
   mips_pkg::word_t    dec_2_ex_imm;
   mips_pkg::reg_num_t dec_2_ex_rs_num;
   mips_pkg::reg_num_t dec_2_ex_rt_num;
   mips_pkg::reg_num_t dec_2_ex_dst;
   mips_pkg::alu_op_t  dec_2_ex_alu_op;
   logic               dec_2_ex_use_imm;
   logic               dec_2_ex_reg_write;
   logic               dec_2_ex_mem_read;
   logic               dec_2_ex_mem_write;

   // EX/MEM
   mips_pkg::word_t    exe_2_mem_alu_res;
   mips_pkg::word_t    exe_2_mem_store;
   mips_pkg::reg_num_t exe_2_mem_dst;
   logic               exe_2_mem_reg_write;
   logic               exe_2_mem_mem_read;
   logic               exe_2_mem_mem_write;

   mips_pkg::fw_sel_t  hz_2_exe_fw_a;
   mips_pkg::fw_sel_t  hz_2_exe_fw_b;

   debug_ctrl inst_debug_ctrl (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_continue (i_continue),
      .i_valid    (i_valid),
      .o_run_enb  (debug_enb)
   );

   fetch_stage inst_fetch_stage (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_enb       (debug_enb),
      .i_stall     (hz_stall),
      .i_taken     (dec_2_fet_taken),
      .i_target    (dec_2_fet_target),
      .i_imem_we   (i_imem_we),
      .i_imem_addr (i_imem_addr),
      .i_imem_data (i_imem_data),
      .o_pc4       (fet_2_dec_pc4),
      .o_instr     (fet_2_dec_instr)
   );

   decode_stage inst_decode_stage (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_enb       (debug_enb),
      .i_pc4       (fet_2_dec_pc4),
      .i_instr     (fet_2_dec_instr),
      .i_bubble    (hz_stall),
      .i_wb_we     (o_wb_we),
      .i_wb_reg    (o_wb_reg),
      .i_wb_data   (o_wb_data),
      .o_taken     (dec_2_fet_taken),
      .o_target    (dec_2_fet_target),
      .o_if_rs     (dec_2_hz_rs),
      .o_if_rt     (dec_2_hz_rt),
      .o_branch    (dec_2_hz_branch),
      .o_rs_val    (dec_2_ex_rs_val),
      .o_rt_val    (dec_2_ex_rt_val),
      .o_imm       (dec_2_ex_imm),
      .o_rs_num    (dec_2_ex_rs_num),
      .o_rt_num    (dec_2_ex_rt_num),
      .o_dst_num   (dec_2_ex_dst),
      .o_alu_op    (dec_2_ex_alu_op),
      .o_use_imm   (dec_2_ex_use_imm),
      .o_reg_write (dec_2_ex_reg_write),
      .o_mem_read  (dec_2_ex_mem_read),
      .o_mem_write (dec_2_ex_mem_write)
   );

   execute_stage inst_execute_stage (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_enb        (debug_enb),
      .i_rs_val     (dec_2_ex_rs_val),
      .i_rt_val     (dec_2_ex_rt_val),
      .i_imm        (dec_2_ex_imm),
      .i_dst_num    (dec_2_ex_dst),
      .i_alu_op     (dec_2_ex_alu_op),
      .i_use_imm    (dec_2_ex_use_imm),
      .i_reg_write  (dec_2_ex_reg_write),
      .i_mem_read   (dec_2_ex_mem_read),
      .i_mem_write  (dec_2_ex_mem_write),
      .i_fw_a       (hz_2_exe_fw_a),
      .i_fw_b       (hz_2_exe_fw_b),
      .i_wb_data    (o_wb_data),
      .o_alu_res    (exe_2_mem_alu_res),
      .o_store_data (exe_2_mem_store),
      .o_dst_num    (exe_2_mem_dst),
      .o_reg_write  (exe_2_mem_reg_write),
      .o_mem_read   (exe_2_mem_mem_read),
      .o_mem_write  (exe_2_mem_mem_write)
   );

   mem_stage inst_mem_stage (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_enb        (debug_enb),
      .i_alu_res    (exe_2_mem_alu_res),
      .i_store_data (exe_2_mem_store),
      .i_dst_num    (exe_2_mem_dst),
      .i_reg_write  (exe_2_mem_reg_write),
      .i_mem_read   (exe_2_mem_mem_read),
      .i_mem_write  (exe_2_mem_mem_write),
      .o_wb_we      (o_wb_we),
      .o_wb_reg     (o_wb_reg),
      .o_wb_data    (o_wb_data)
   );

   hazard_unit inst_hazard_unit (
      .i_if_rs     (dec_2_hz_rs),
      .i_if_rt     (dec_2_hz_rt),
      .i_ex_rs     (dec_2_ex_rs_num),
      .i_ex_rt     (dec_2_ex_rt_num),
      .i_ex_dst    (dec_2_ex_dst),
      .i_ex_write  (dec_2_ex_reg_write),
      .i_ex_read   (dec_2_ex_mem_read),
      .i_mem_dst   (exe_2_mem_dst),
      .i_mem_write (exe_2_mem_reg_write),
      .i_wb_dst    (o_wb_reg),
      .i_wb_write  (o_wb_we),
      .i_branch    (dec_2_hz_branch),
      .o_fw_a      (hz_2_exe_fw_a),
      .o_fw_b      (hz_2_exe_fw_b),
      .o_stall     (hz_stall)
   );

endmodule

/* rtl/mips_pkg.sv */
`include "mips_cfg.svh"

package mips_pkg;

   typedef logic [`NB_BITS-1:0]      word_t;
   typedef logic [`NB_REG-1:0]       reg_num_t;
   typedef logic [`NB_IMEM_ADDR-1:0] imem_addr_t;
   typedef logic [2:0]               alu_op_t;
   typedef logic [1:0]               fw_sel_t;

   localparam alu_op_t ALU_ADD = 3'd0;
   localparam alu_op_t ALU_SUB = 3'd1;
   localparam alu_op_t ALU_AND = 3'd2;
   localparam alu_op_t ALU_OR  = 3'd3;
   localparam alu_op_t ALU_SLT = 3'd4;

   // operand source in execute
   localparam fw_sel_t FW_RF    = 2'd0;
   localparam fw_sel_t FW_EXMEM = 2'd1;
   localparam fw_sel_t FW_MEMWB = 2'd2;

   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_J     = 6'h02;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   // funct field, r-type only
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_SLT  = 6'h2a;

   typedef enum logic [1:0] {
      HALT = 2'd0,
      RUN  = 2'd1,
      STEP = 2'd2
   } dbg_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
   -f mips_core.f --top-module mips_core_tb -o mips_core_sim
./obj_dir/mips_core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation passed"

/* testbench/mips_core_assertions.sv */
`timescale 1ns/10ps

module mips_core_assertions (
   input logic               i_clk,
   input logic               i_arst_n,
   input logic               i_run_enb,
   input logic               i_wb_we,
   input mips_pkg::reg_num_t i_wb_reg
);

   wb_idle_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !i_wb_we)
      else $error("write-back enable high during reset");

   // r0 is filtered before the MEM/WB latch
   wb_never_r0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                                 i_wb_we |-> (i_wb_reg != '0))
      else $error("write-back addressed to r0");

   wb_quiet_halted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                                     !i_run_enb |-> !i_wb_we)
      else $error("write-back enable high while the core is halted");

endmodule

bind mips_core mips_core_assertions assertions_i (
   .i_clk     (i_clk),
   .i_arst_n  (i_arst_n),
   .i_run_enb (debug_enb),   // debug_ctrl output inside the top
   .i_wb_we   (o_wb_we),
   .i_wb_reg  (o_wb_reg)
);

/* testbench/mips_core_tb.sv */
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mips_core_tb;

   localparam int PROG_LEN    = 48;
   localparam int TAIL_CYCLES = 20;
   // run budget plus reset, program load, five steps and the idle tail
   localparam int CYCLE_LIMIT = 4 * PROG_LEN + 100 + 4 + `IMEM_DEPTH + 30 + TAIL_CYCLES;

   logic                 i_clk;
   logic                 i_arst_n;
   logic                 i_continue;
   logic                 i_valid;
   logic                 i_imem_we;
   mips_pkg::imem_addr_t i_imem_addr;
   mips_pkg::word_t      i_imem_data;
   logic                 o_wb_we;
   mips_pkg::reg_num_t   o_wb_reg;
   mips_pkg::word_t      o_wb_data;

   mips_pkg::word_t      prog [`IMEM_DEPTH];
   mips_pkg::reg_num_t   exp_reg [$];    // expected write-backs in program order
   mips_pkg::word_t      exp_data [$];
   logic [31:0]          lfsr_state;
   int                   exp_total;
   int                   wb_seen = 0;
   int                   cycle_cnt = 0;

   mips_core dut_i (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_continue  (i_continue),
      .i_valid     (i_valid),
      .i_imem_we   (i_imem_we),
      .i_imem_addr (i_imem_addr),
      .i_imem_data (i_imem_data),
      .o_wb_we     (o_wb_we),
      .o_wb_reg    (o_wb_reg),
      .o_wb_data   (o_wb_data)
   );

   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
   endfunction

   // one lfsr step per bit
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic mips_pkg::reg_num_t pick_reg();
      logic [2:0] v;
      v = 3'(take_bits(3));
      return (v == 3'd0) ? 5'd7 : {2'b00, v};   // r1..r7 only
   endfunction

   function automatic mips_pkg::word_t rtype_word(mips_pkg::reg_num_t rs, mips_pkg::reg_num_t rt,
                                                  mips_pkg::reg_num_t rd, logic [5:0] fn);
      return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic mips_pkg::word_t itype_word(logic [5:0] op, mips_pkg::reg_num_t rs,
                                                  mips_pkg::reg_num_t rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic mips_pkg::word_t jump_word(int t);
      return {mips_pkg::OP_J, 26'(t)};
   endfunction

   task automatic report_and_stop(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic build_program();
      int                 kind;
      int                 tgt;
      mips_pkg::reg_num_t rs;
      mips_pkg::reg_num_t rt;
      mips_pkg::reg_num_t rd;
      for (int a = 0; a < `IMEM_DEPTH; a++) begin
         prog[a] = '0;   // nop fill
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         kind = int'(take_bits(4));
         rs   = pick_reg();
         rt   = pick_reg();
         rd   = pick_reg();
         if (i == 0 || (kind == 14 && i == PROG_LEN - 1)) begin
            kind = 6;   // addiu so the first write shows up after five steps
         end
         case (kind)
            0, 1:   prog[i] = rtype_word(rs, rt, rd, mips_pkg::FN_ADDU);
            2:      prog[i] = rtype_word(rs, rt, rd, mips_pkg::FN_SUBU);
            3:      prog[i] = rtype_word(rs, rt, rd, mips_pkg::FN_AND);
            4:      prog[i] = rtype_word(rs, rt, rd, mips_pkg::FN_OR);
            5:      prog[i] = rtype_word(rs, rt, rd, mips_pkg::FN_SLT);
            8, 9:   prog[i] = itype_word(mips_pkg::OP_LW, 5'd0, rt,
                                         {9'd0, 5'(take_bits(5)), 2'b00});
            10, 11: prog[i] = itype_word(mips_pkg::OP_SW, 5'd0, rt,
                                         {9'd0, 5'(take_bits(5)), 2'b00});
            12, 13: begin
               if (take_bits(1) != 0) begin
                  rt = rs;   // always taken
               end
               prog[i] = itype_word(mips_pkg::OP_BEQ, rs, rt, 16'(1 + take_bits(2) % 3));
            end
            14: begin
               tgt = i + 1 + int'(take_bits(2));
               if (tgt > PROG_LEN - 1) begin
                  tgt = PROG_LEN - 1;
               end
               prog[i] = jump_word(tgt);
            end
            default: prog[i] = itype_word(mips_pkg::OP_ADDIU, rs, rt, 16'(take_bits(16)));
         endcase
      end
   endtask

   // in-order instruction-set model without a pipeline
   task automatic run_model();
      mips_pkg::word_t    regs [32];
      mips_pkg::word_t    dmem [`DMEM_DEPTH];
      mips_pkg::word_t    ins;
      mips_pkg::word_t    a;
      mips_pkg::word_t    b;
      mips_pkg::word_t    sext;
      mips_pkg::word_t    ea;
      mips_pkg::word_t    res;
      mips_pkg::reg_num_t dst;
      logic               wr;
      int                 pc;
      for (int k = 0; k < 32; k++) begin
         regs[k] = '0;
      end
      for (int k = 0; k < `DMEM_DEPTH; k++) begin
         dmem[k] = '0;
      end
      pc = 0;
      while (pc < PROG_LEN) begin
         ins  = prog[pc];
         a    = regs[ins[25:21]];
         b    = regs[ins[20:16]];
         sext = {{16{ins[15]}}, ins[15:0]};
         ea   = a + sext;
         wr   = 1'b0;
         dst  = ins[20:16];
         res  = '0;
         pc   = pc + 1;
         case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
               wr  = 1'b1;
               dst = ins[15:11];
               case (ins[5:0])
                  mips_pkg::FN_ADDU: res = a + b;
                  mips_pkg::FN_SUBU: res = a - b;
                  mips_pkg::FN_AND:  res = a & b;
                  mips_pkg::FN_OR:   res = a | b;
                  mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default:           wr = 1'b0;
               endcase
            end
            mips_pkg::OP_ADDIU: begin
               wr  = 1'b1;
               res = ea;
            end
            mips_pkg::OP_LW: begin
               wr  = 1'b1;
               res = dmem[ea[`NB_DMEM_ADDR+1:2]];
            end
            mips_pkg::OP_SW:  dmem[ea[`NB_DMEM_ADDR+1:2]] = b;
            mips_pkg::OP_BEQ: pc = (a == b) ? pc + int'(sext) : pc;
            mips_pkg::OP_J:   pc = int'(ins[25:0]);
            default: ;
         endcase
         if (wr && dst != '0) begin
            regs[dst] = res;
            exp_reg.push_back(dst);
            exp_data.push_back(res);
         end
      end
   endtask

   // held over three edges so only the rising edge may count
   task automatic step_once();
      @(negedge i_clk);
      i_valid = 1'b1;
      repeat (3) @(negedge i_clk);
      i_valid = 1'b0;
      @(negedge i_clk);
   endtask

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         report_and_stop($sformatf("timeout after %0d cycles with %0d of %0d write-backs",
                                   cycle_cnt, wb_seen, exp_total));
      end
   end

   // mid-cycle sampling of the write-back port
   always @(negedge i_clk) begin
      if (i_arst_n && o_wb_we) begin
         wb_seen++;
         assert (exp_reg.size() > 0)
            else report_and_stop("write-back seen after the last expected one");
         assert (o_wb_reg == exp_reg[0])
            else report_and_stop($sformatf("Error o_wb_reg expected %h got %h",
                                           exp_reg[0], o_wb_reg));
         assert (o_wb_data == exp_data[0])
            else report_and_stop($sformatf("Error o_wb_data expected %h got %h",
                                           exp_data[0], o_wb_data));
         exp_reg.pop_front();
         exp_data.pop_front();
      end
   end

   initial begin
      i_arst_n    = 1'b0;
      i_continue  = 1'b0;
      i_valid     = 1'b0;
      i_imem_we   = 1'b0;
      i_imem_addr = '0;
      i_imem_data = '0;
      lfsr_state  = 32'h291a_5050;
      build_program();
      run_model();
      exp_total = exp_reg.size();

      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_arst_n = 1'b1;

      for (int a = 0; a < `IMEM_DEPTH; a++) begin
         @(negedge i_clk);
         i_imem_we   = 1'b1;
         i_imem_addr = mips_pkg::imem_addr_t'(a);
         i_imem_data = prog[a];
      end
      @(negedge i_clk);
      i_imem_we = 1'b0;
      @(posedge i_clk);
      assert (wb_seen == 0) else report_and_stop("write-back seen while loading the halted core");

      // four steps fill the pipe and the fifth retires instruction 0
      repeat (4) step_once();
      @(posedge i_clk);
      assert (wb_seen == 0) else report_and_stop("write-back seen before the fifth single step");
      step_once();
      repeat (3) @(posedge i_clk);
      assert (wb_seen == 1)
         else report_and_stop($sformatf("%0d write-backs after five single steps, one expected",
                                        wb_seen));

      @(negedge i_clk);
      i_continue = 1'b1;
      wait (wb_seen == exp_total);
      repeat (TAIL_CYCLES) @(negedge i_clk);   // extra writes would show up here

      $display("Everything OK");
      $finish;
   end

endmodule
